/* flist.f */
hw/dcache_pkg.sv
hw/dcache_stage_if.sv
hw/dcache_tag_stage.sv
hw/dcache_data_array.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
sim/dcache_checker.sv
sim/dcache_monitor.sv
sim/tb_dcache.sv

/* hw/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
	input wire logic clk,
	input wire logic rst,
	dcache_stage_if.dst lk,
	// tag install at the end of a refill
	output logic fill_done,
	output dcache_pkg::way_mask_t fill_way,
	// data array
	output logic rd_en,
	output dcache_pkg::way_mask_t rd_way,
	output logic [dcache_pkg::IDX_W+dcache_pkg::OFF_W-1:0] rd_addr,
	input wire logic [dcache_pkg::DATA_W-1:0] rd_data,
	output logic wr_en,
	output dcache_pkg::way_mask_t wr_way,
	output logic [dcache_pkg::IDX_W+dcache_pkg::OFF_W-1:0] wr_addr,
	output logic [dcache_pkg::DATA_W-1:0] wr_data,
	output logic [dcache_pkg::STRB_W-1:0] wr_strb,
	// core response
	output logic rsp_valid,
	output logic [dcache_pkg::DATA_W-1:0] rsp_rdata,
	// axi4 master
	output logic [dcache_pkg::ADDR_W-1:0] m_araddr,
	output logic [7:0] m_arlen,
	output logic [2:0] m_arsize,
	output logic [1:0] m_arburst,
	output logic m_arvalid,
	input wire logic m_arready,
	input wire logic [dcache_pkg::DATA_W-1:0] m_rdata,
	input wire logic m_rlast,
	input wire logic m_rvalid,
	output logic m_rready,
	output logic [dcache_pkg::ADDR_W-1:0] m_awaddr,
	output logic [7:0] m_awlen,
	output logic [2:0] m_awsize,
	output logic [1:0] m_awburst,
	output logic m_awvalid,
	input wire logic m_awready,
	output logic [dcache_pkg::DATA_W-1:0] m_wdata,
	output logic [dcache_pkg::STRB_W-1:0] m_wstrb,
	output logic m_wlast,
	output logic m_wvalid,
	input wire logic m_wready,
	input wire logic m_bvalid,
	output logic m_bready
);
	import dcache_pkg::*;

	dc_state_e state;
	dc_state_e state_nx;
	logic [IDX_W-1:0] idx;
	logic [OFF_W-1:0] off;
	logic rd_hit;
	logic wr_hit;
	logic r_hs;
	logic done;
	logic [DATA_W-1:0] done_data;
	logic rd_pend;
	logic [OFF_W-1:0] beat_cnt;
	logic [DATA_W-1:0] fill_word;

	assign idx = lk.addr[BYTE_OFF_W+OFF_W +: IDX_W];
	assign off = lk.addr[BYTE_OFF_W +: OFF_W];
	assign rd_hit = lk.valid && lk.hit && !lk.wren;
	assign wr_hit = lk.valid && lk.hit && lk.wren;
	assign r_hs = m_rvalid && m_rready;

	// last cycle of a stalled operation, the lookup stage may move on
	always_comb begin
		case (state)
			ST_REFILL: done = r_hs && m_rlast;
			ST_UNC_READ: done = r_hs;
			ST_WR_RESP: done = m_bvalid;
			default: done = 1'b0;
		endcase
	end

	// read hits pass, anything else holds the stage until done
	assign lk.stall = (state == ST_IDLE) ? (lk.valid && !rd_hit) : !done;

	// read request: whole line for cached misses, one word otherwise
	assign m_arvalid = (state == ST_IDLE) && lk.valid && !lk.wren && !lk.hit;
	assign m_araddr = lk.cached ?
		{lk.addr[ADDR_W-1:BYTE_OFF_W+OFF_W], {(BYTE_OFF_W+OFF_W){1'b0}}} :
		{lk.addr[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};
	assign m_arlen = lk.cached ? 8'(LINE_BEATS-1) : 8'd0;
	assign m_arsize = AXI_SIZE_WORD;
	assign m_arburst = AXI_BURST_INCR;
	assign m_rready = 1'b1;

	// every write goes through as one beat
	assign m_awvalid = (state == ST_IDLE) && lk.valid && lk.wren;
	assign m_awaddr = {lk.addr[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};
	assign m_awlen = 8'd0;
	assign m_awsize = AXI_SIZE_WORD;
	assign m_awburst = AXI_BURST_INCR;
	assign m_wvalid = state == ST_WR_DATA;
	assign m_wdata = lk.wdata;
	assign m_wstrb = lk.wstrb;
	assign m_wlast = 1'b1;
	assign m_bready = 1'b1;

	always_comb begin
		state_nx = state;
		case (state)
			ST_IDLE: begin
				if (m_arvalid && m_arready)
					state_nx = lk.cached ? ST_REFILL : ST_UNC_READ;
				else if (m_awvalid && m_awready)
					state_nx = ST_WR_DATA;
			end
			ST_REFILL, ST_UNC_READ, ST_WR_RESP: begin
				if (done)
					state_nx = ST_IDLE;
			end
			ST_WR_DATA: begin
				if (m_wready)
					state_nx = ST_WR_RESP;
			end
			default: state_nx = ST_IDLE;
		endcase
	end

	// hit read goes to the array right away
	assign rd_en = (state == ST_IDLE) && rd_hit;
	assign rd_way = lk.hit_way;
	assign rd_addr = {idx, off};

	// refill beats into the victim, else a write hit once on the aw handshake
	always_comb begin
		if (state == ST_REFILL) begin
			wr_en = r_hs;
			wr_way = lk.victim_way;
			wr_addr = {idx, beat_cnt};
			wr_data = m_rdata;
			wr_strb = '1;
		end else begin
			wr_en = (state == ST_IDLE) && wr_hit && m_awready;
			wr_way = lk.hit_way;
			wr_addr = {idx, off};
			wr_data = lk.wdata;
			wr_strb = lk.wstrb;
		end
	end

	assign fill_done = (state == ST_REFILL) && r_hs && m_rlast;
	assign fill_way = lk.victim_way;

	// word returned when the stall ends, zero for writes
	always_comb begin
		case (state)
			ST_REFILL: done_data = (beat_cnt == off) ? m_rdata : fill_word;
			ST_UNC_READ: done_data = m_rdata;
			default: done_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			beat_cnt <= '0;
			rd_pend <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			state <= state_nx;
			if (state == ST_REFILL && r_hs)
				beat_cnt <= beat_cnt + 1'b1;
			else if (state == ST_IDLE)
				beat_cnt <= '0;
			rd_pend <= rd_en;
			rsp_valid <= rd_pend || done;
		end
	end

	// requested word is kept as its beat passes by
	always_ff @(posedge clk) begin
		if (state == ST_REFILL && r_hs && beat_cnt == off)
			fill_word <= m_rdata;
		rsp_rdata <= rd_pend ? rd_data : done_data;
	end

endmodule

`default_nettype wire

/* hw/dcache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array (
	input wire logic clk,
	// read port, data one cycle after rd_en
	input wire logic rd_en,
	input wire dcache_pkg::way_mask_t rd_way,
	input wire logic [dcache_pkg::IDX_W+dcache_pkg::OFF_W-1:0] rd_addr,
	output logic [dcache_pkg::DATA_W-1:0] rd_data,
	// write port with byte strobes
	input wire logic wr_en,
	input wire dcache_pkg::way_mask_t wr_way,
	input wire logic [dcache_pkg::IDX_W+dcache_pkg::OFF_W-1:0] wr_addr,
	input wire logic [dcache_pkg::DATA_W-1:0] wr_data,
	input wire logic [dcache_pkg::STRB_W-1:0] wr_strb
);
	import dcache_pkg::*;

	// words of all ways in one store, way number on top of {index, offset}
	localparam int WORDS = NUM_WAYS * NUM_SETS * LINE_BEATS;
	localparam int WAY_W = $clog2(NUM_WAYS);
	localparam int SEL_W = WAY_W + IDX_W + OFF_W;
	localparam int BYTE_W = DATA_W / STRB_W;

	logic [DATA_W-1:0] mem [WORDS];
	logic [SEL_W-1:0] rd_sel;
	logic [SEL_W-1:0] wr_sel;

	// one-hot way to its number
	function automatic logic [WAY_W-1:0] way_num(input way_mask_t way);
		logic [WAY_W-1:0] n;
		n = '0;
		for (int w = 0; w < NUM_WAYS; w++)
			if (way[w])
				n = WAY_W'(w);
		return n;
	endfunction

	assign rd_sel = {way_num(rd_way), rd_addr};
	assign wr_sel = {way_num(wr_way), wr_addr};

	// partial stores touch only the enabled bytes
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < STRB_W; b++)
				if (wr_strb[b])
					mem[wr_sel][b*BYTE_W +: BYTE_W] <= wr_data[b*BYTE_W +: BYTE_W];
		end
	end

	// registered read, output holds between reads
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_sel];
	end

endmodule

`default_nettype wire

/* hw/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

	// physical address and core word
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int STRB_W = 8;
	// byte offset inside a word, log2 of STRB_W
	localparam int BYTE_OFF_W = 3;

	// cache geometry: 4 ways x 16 sets x 64-byte lines
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 16;
	// set index from addr[9:6]
	localparam int IDX_W = 4;
	// word within the line from addr[5:3]
	localparam int OFF_W = 3;
	// tag from addr[31:10]
	localparam int TAG_W = 22;
	localparam int LINE_BEATS = 8;

	// everything from here up goes straight to memory
	localparam logic [ADDR_W-1:0] UNCACHED_BASE = 32'h9000_0000;

	// axi4 encodings used by the master
	localparam logic [2:0] AXI_SIZE_WORD = 3'd3;
	localparam logic [1:0] AXI_BURST_INCR = 2'b01;

	// one-hot way, or all zero when nothing is selected
	typedef logic [NUM_WAYS-1:0] way_mask_t;

	// access stage controller
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_REFILL,
		ST_UNC_READ,
		ST_WR_DATA,
		ST_WR_RESP
	} dc_state_e;

endpackage

`default_nettype wire

/* hw/dcache_stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dcache_stage_if;
	import dcache_pkg::*;

	// request held in the lookup stage
	logic valid;
	logic [ADDR_W-1:0] addr;
	logic wren;
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	// lookup result for the held request
	logic hit;
	way_mask_t hit_way;
	way_mask_t victim_way;
	logic cached;
	// access stage busy, freezes the lookup stage
	logic stall;

	modport src (
		output valid, addr, wren, wdata, wstrb, hit, hit_way, victim_way, cached,
		input stall
	);

	modport dst (
		input valid, addr, wren, wdata, wstrb, hit, hit_way, victim_way, cached,
		output stall
	);

endinterface

`default_nettype wire

/* hw/dcache_tag_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_stage (
	input wire logic clk,
	input wire logic rst,
	input wire logic req_valid,
	input wire logic req_wren,
	input wire logic [dcache_pkg::ADDR_W-1:0] req_addr,
	input wire logic [dcache_pkg::DATA_W-1:0] req_wdata,
	input wire logic [dcache_pkg::STRB_W-1:0] req_wstrb,
	output logic req_ready,
	dcache_stage_if.src lk,
	input wire logic fill_done,
	input wire dcache_pkg::way_mask_t fill_way
);
	import dcache_pkg::*;

	logic ready_q;
	logic accept;
	// stage register
	logic stg_valid;
	logic [ADDR_W-1:0] stg_addr;
	logic stg_wren;
	logic [DATA_W-1:0] stg_wdata;
	logic [STRB_W-1:0] stg_wstrb;
	// tag store and valid bits, one row per way
	logic [TAG_W-1:0] tag_mem [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] vld [NUM_WAYS];
	way_mask_t victim;
	way_mask_t hit_way;
	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic cached;

	assign idx = stg_addr[BYTE_OFF_W+OFF_W +: IDX_W];
	assign tag = stg_addr[ADDR_W-1 -: TAG_W];
	assign cached = stg_addr < UNCACHED_BASE;

	// ready comes up one cycle out of reset, then follows stall
	assign req_ready = ready_q && !lk.stall;
	assign accept = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			ready_q <= 1'b0;
			stg_valid <= 1'b0;
			victim <= way_mask_t'(1);
		end else begin
			ready_q <= 1'b1;
			// a stalled request stays put until the controller lets go
			if (!lk.stall)
				stg_valid <= accept;
			// pointer only moves while nothing is being looked up
			if (!stg_valid)
				victim <= {victim[NUM_WAYS-2:0], victim[NUM_WAYS-1]};
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			stg_addr <= req_addr;
			stg_wren <= req_wren;
			stg_wdata <= req_wdata;
			stg_wstrb <= req_wstrb;
		end
	end

	// valid bit set by the last refill beat
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++)
				vld[w] <= '0;
		end else if (fill_done) begin
			for (int w = 0; w < NUM_WAYS; w++)
				if (fill_way[w])
					vld[w][idx] <= 1'b1;
		end
	end

	// tag of the held address goes into the refilled way
	always_ff @(posedge clk) begin
		if (fill_done) begin
			for (int w = 0; w < NUM_WAYS; w++)
				if (fill_way[w])
					tag_mem[w][idx] <= tag;
		end
	end

	// compare all ways of the held set, uncached space never hits
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++)
			hit_way[w] = vld[w][idx] && (tag_mem[w][idx] == tag) && cached;
	end

	assign lk.valid = stg_valid;
	assign lk.addr = stg_addr;
	assign lk.wren = stg_wren;
	assign lk.wdata = stg_wdata;
	assign lk.wstrb = stg_wstrb;
	assign lk.hit = |hit_way;
	assign lk.hit_way = hit_way;
	assign lk.victim_way = victim;
	assign lk.cached = cached;

endmodule

`default_nettype wire

/* hw/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
	input wire logic clk,
	input wire logic rst,
	// core request and response
	input wire logic req_valid,
	input wire logic req_wren,
	input wire logic [dcache_pkg::ADDR_W-1:0] req_addr,
	input wire logic [dcache_pkg::DATA_W-1:0] req_wdata,
	input wire logic [dcache_pkg::STRB_W-1:0] req_wstrb,
	output logic req_ready,
	output logic rsp_valid,
	output logic [dcache_pkg::DATA_W-1:0] rsp_rdata,
	// axi4 master towards memory
	output logic [dcache_pkg::ADDR_W-1:0] m_araddr,
	output logic [7:0] m_arlen,
	output logic [2:0] m_arsize,
	output logic [1:0] m_arburst,
	output logic m_arvalid,
	input wire logic m_arready,
	input wire logic [dcache_pkg::DATA_W-1:0] m_rdata,
	input wire logic m_rlast,
	input wire logic m_rvalid,
	output logic m_rready,
	output logic [dcache_pkg::ADDR_W-1:0] m_awaddr,
	output logic [7:0] m_awlen,
	output logic [2:0] m_awsize,
	output logic [1:0] m_awburst,
	output logic m_awvalid,
	input wire logic m_awready,
	output logic [dcache_pkg::DATA_W-1:0] m_wdata,
	output logic [dcache_pkg::STRB_W-1:0] m_wstrb,
	output logic m_wlast,
	output logic m_wvalid,
	input wire logic m_wready,
	input wire logic m_bvalid,
	output logic m_bready
);
	import dcache_pkg::*;

	// lookup stage to access stage
	dcache_stage_if lk ();

	logic fill_done;
	way_mask_t fill_way;
	logic rd_en;
	way_mask_t rd_way;
	logic [IDX_W+OFF_W-1:0] rd_addr;
	logic [DATA_W-1:0] rd_data;
	logic wr_en;
	way_mask_t wr_way;
	logic [IDX_W+OFF_W-1:0] wr_addr;
	logic [DATA_W-1:0] wr_data;
	logic [STRB_W-1:0] wr_strb;

	dcache_tag_stage u_tag_stage (
		.clk, .rst,
		.req_valid, .req_wren, .req_addr, .req_wdata, .req_wstrb, .req_ready,
		.lk(lk.src),
		.fill_done, .fill_way
	);

	dcache_data_array u_data_array (
		.clk,
		.rd_en, .rd_way, .rd_addr, .rd_data,
		.wr_en, .wr_way, .wr_addr, .wr_data, .wr_strb
	);

	dcache_ctrl u_ctrl (
		.clk, .rst,
		.lk(lk.dst),
		.fill_done, .fill_way,
		.rd_en, .rd_way, .rd_addr, .rd_data,
		.wr_en, .wr_way, .wr_addr, .wr_data, .wr_strb,
		.rsp_valid, .rsp_rdata,
		.m_araddr, .m_arlen, .m_arsize, .m_arburst, .m_arvalid, .m_arready,
		.m_rdata, .m_rlast, .m_rvalid, .m_rready,
		.m_awaddr, .m_awlen, .m_awsize, .m_awburst, .m_awvalid, .m_awready,
		.m_wdata, .m_wstrb, .m_wlast, .m_wvalid, .m_wready,
		.m_bvalid, .m_bready
	);

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the dcache testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dcache -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_dcache)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "All checks passed" <<< "$out"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* sim/dcache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
	input wire logic clk,
	input wire logic rst,
	input wire logic req_valid,
	input wire logic req_ready,
	input wire logic rsp_valid,
	input wire logic m_arvalid,
	input wire logic m_arready,
	input wire logic [dcache_pkg::ADDR_W-1:0] m_araddr,
	input wire logic [7:0] m_arlen,
	input wire logic m_awvalid,
	input wire logic m_awready,
	input wire logic [dcache_pkg::ADDR_W-1:0] m_awaddr,
	input wire logic m_wvalid,
	input wire logic m_wready,
	input wire logic [dcache_pkg::DATA_W-1:0] m_wdata,
	input wire logic [dcache_pkg::STRB_W-1:0] m_wstrb
);
	import dcache_pkg::*;

	// requests accepted but not yet answered
	int outstanding;

	always @(posedge clk) begin
		if (rst)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(req_valid && req_ready) - int'(rsp_valid);
	end

	ar_hold: assert property (@(posedge clk) disable iff (rst)
		m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr) && $stable(m_arlen))
		else $error("arvalid dropped or ar payload changed before arready");

	aw_hold: assert property (@(posedge clk) disable iff (rst)
		m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr))
		else $error("awvalid dropped or awaddr changed before awready");

	w_hold: assert property (@(posedge clk) disable iff (rst)
		m_wvalid && !m_wready |=> m_wvalid && $stable(m_wdata) && $stable(m_wstrb))
		else $error("wvalid dropped or w payload changed before wready");

	rsp_owed: assert property (@(posedge clk) disable iff (rst)
		rsp_valid |-> outstanding > 0)
		else $error("rsp_valid without an outstanding request");

	// line bursts start on a line boundary below the uncached base
	// single beats are word reads at or above it
	arlen_legal: assert property (@(posedge clk) disable iff (rst)
		m_arvalid |->
			(m_arlen == 8'd7 && m_araddr < UNCACHED_BASE && m_araddr[5:0] == 6'd0) ||
			(m_arlen == 8'd0 && m_araddr >= UNCACHED_BASE && m_araddr[2:0] == 3'd0))
		else $error("arlen does not match the region and alignment of araddr");

endmodule

bind dcache_top dcache_checker u_checker (.*);

`default_nettype wire

/* sim/dcache_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_monitor (
	input wire logic clk,
	input wire logic rst,
	input wire logic req_valid,
	input wire logic req_ready,
	input wire logic req_wren,
	input wire logic [dcache_pkg::ADDR_W-1:0] req_addr,
	input wire logic [dcache_pkg::DATA_W-1:0] req_wdata,
	input wire logic [dcache_pkg::STRB_W-1:0] req_wstrb,
	input wire logic rsp_valid,
	input wire logic [dcache_pkg::DATA_W-1:0] rsp_rdata,
	input wire logic m_arvalid,
	input wire logic m_arready,
	input wire logic [7:0] m_arlen,
	input wire logic [2:0] m_arsize,
	input wire logic [1:0] m_arburst,
	input wire logic m_rvalid,
	input wire logic m_rready,
	input wire logic m_awvalid,
	input wire logic m_awready,
	input wire logic [7:0] m_awlen,
	input wire logic [2:0] m_awsize,
	input wire logic [1:0] m_awburst,
	input wire logic m_wvalid,
	input wire logic m_wready,
	input wire logic [dcache_pkg::STRB_W-1:0] m_wstrb,
	input wire logic m_wlast,
	input wire logic m_bvalid,
	input wire logic m_bready
);
	import dcache_pkg::*;

	// reference copy of memory keyed by word address
	logic [DATA_W-1:0] shadow [logic [ADDR_W-4:0]];
	// expected word, address and accept cycle per outstanding request
	logic [DATA_W-1:0] exp_q [$];
	logic [ADDR_W-1:0] addr_q [$];
	int acc_q [$];
	int cyc = 0;
	int err_cnt = 0;
	int pending = 0;
	int rsp_cnt = 0;
	// responses that did not come two edges after acceptance
	int slow_cnt = 0;
	int ar_line = 0;
	int ar_single = 0;
	int aw_cnt = 0;
	logic [STRB_W-1:0] last_wstrb = '0;
	logic [DATA_W-1:0] exp_word;
	logic [ADDR_W-1:0] exp_addr;
	int lat;

	// untouched words hold their own address xor a marker
	function automatic logic [DATA_W-1:0] ref_word(input logic [ADDR_W-1:0] a);
		if (shadow.exists(a[ADDR_W-1:3]))
			return shadow[a[ADDR_W-1:3]];
		return {32'h0, a[ADDR_W-1:3], 3'b000} ^ 64'hA5A5_0000_0000_0000;
	endfunction

	// only the enabled bytes change
	function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] old,
			input logic [DATA_W-1:0] wd, input logic [STRB_W-1:0] st);
		logic [DATA_W-1:0] r;
		r = old;
		for (int b = 0; b < STRB_W; b++)
			if (st[b])
				r[b*8 +: 8] = wd[b*8 +: 8];
		return r;
	endfunction

	// one axi control field against the value the bus use calls for
	task automatic expect_field(input string name, input logic [7:0] exp,
			input logic [7:0] got);
		if (got !== exp) begin
			$display("CHECK FAILED %s expected %h got %h", name, exp, got);
			err_cnt++;
		end
	endtask

	always @(posedge clk) begin
		if (!rst) begin
			cyc++;
			// responses leave in request order
			if (rsp_valid) begin
				if (exp_q.size() == 0) begin
					$display("response arrived with no outstanding request");
					err_cnt++;
				end else begin
					exp_word = exp_q.pop_front();
					exp_addr = addr_q.pop_front();
					lat = cyc - acc_q.pop_front() - 1;
					if (rsp_rdata !== exp_word) begin
						$display("CHECK FAILED rsp_rdata addr %h expected %h got %h",
							exp_addr, exp_word, rsp_rdata);
						err_cnt++;
					end
					if (lat != 2)
						slow_cnt++;
					rsp_cnt++;
					pending--;
				end
			end
			// expected value is fixed at acceptance and writes answer zero
			if (req_valid && req_ready) begin
				exp_q.push_back(req_wren ? '0 : ref_word(req_addr));
				addr_q.push_back(req_addr);
				acc_q.push_back(cyc);
				if (req_wren)
					shadow[req_addr[ADDR_W-1:3]] =
						merge(ref_word(req_addr), req_wdata, req_wstrb);
				pending++;
			end
			if (m_arvalid && m_arready) begin
				if (m_arlen == 8'd7)
					ar_line++;
				else
					ar_single++;
				// 8-byte beats in an incrementing burst
				expect_field("m_arsize", 8'd3, 8'(m_arsize));
				expect_field("m_arburst", 8'd1, 8'(m_arburst));
			end
			if (m_rvalid)
				expect_field("m_rready", 8'd1, 8'(m_rready));
			if (m_awvalid && m_awready) begin
				aw_cnt++;
				// writes are always one 8-byte beat
				expect_field("m_awlen", 8'd0, m_awlen);
				expect_field("m_awsize", 8'd3, 8'(m_awsize));
				expect_field("m_awburst", 8'd1, 8'(m_awburst));
			end
			if (m_wvalid && m_wready) begin
				last_wstrb = m_wstrb;
				expect_field("m_wlast", 8'd1, 8'(m_wlast));
			end
			if (m_bvalid)
				expect_field("m_bready", 8'd1, 8'(m_bready));
		end
	end

endmodule

`default_nettype wire

/* sim/tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
	import dcache_pkg::*;

	logic clk;
	logic rst;
	logic req_valid;
	logic req_wren;
	logic [ADDR_W-1:0] req_addr;
	logic [DATA_W-1:0] req_wdata;
	logic [STRB_W-1:0] req_wstrb;
	logic req_ready;
	logic rsp_valid;
	logic [DATA_W-1:0] rsp_rdata;
	logic [ADDR_W-1:0] m_araddr;
	logic [7:0] m_arlen;
	logic [2:0] m_arsize;
	logic [1:0] m_arburst;
	logic m_arvalid;
	logic m_arready;
	logic [DATA_W-1:0] m_rdata;
	logic m_rlast;
	logic m_rvalid;
	logic m_rready;
	logic [ADDR_W-1:0] m_awaddr;
	logic [7:0] m_awlen;
	logic [2:0] m_awsize;
	logic [1:0] m_awburst;
	logic m_awvalid;
	logic m_awready;
	logic [DATA_W-1:0] m_wdata;
	logic [STRB_W-1:0] m_wstrb;
	logic m_wlast;
	logic m_wvalid;
	logic m_wready;
	logic m_bvalid;
	logic m_bready;

	// memory behind the axi slave
	// words never written read as their address xor a marker
	logic [DATA_W-1:0] mem [logic [ADDR_W-4:0]];
	int issued = 0;
	int cycles = 0;
	int tb_err = 0;
	int err_base = 0;
	int test_no = 1;
	// counter snapshots taken at the start of a test
	int ar_l0;
	int ar_s0;
	int aw0;
	int slow0;
	int rsp0;

	dcache_top u_dcache_top (.*);

	dcache_monitor u_mon (
		.clk, .rst,
		.req_valid, .req_ready, .req_wren, .req_addr, .req_wdata, .req_wstrb,
		.rsp_valid, .rsp_rdata,
		.m_arvalid, .m_arready, .m_arlen, .m_arsize, .m_arburst,
		.m_rvalid, .m_rready,
		.m_awvalid, .m_awready, .m_awlen, .m_awsize, .m_awburst,
		.m_wvalid, .m_wready, .m_wstrb, .m_wlast,
		.m_bvalid, .m_bready
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
		if (mem.exists(a[ADDR_W-1:3]))
			return mem[a[ADDR_W-1:3]];
		return {32'h0, a[ADDR_W-1:3], 3'b000} ^ 64'hA5A5_0000_0000_0000;
	endfunction

	// {tag, set, word, byte}
	function automatic logic [ADDR_W-1:0] line_addr(input int tag, input int set, input int off);
		return {22'(tag), 4'(set), 3'(off), 3'b000};
	endfunction

	// axi slave serving one transaction at a time with 0 to 3 cycles of delay per step
	initial begin
		logic [ADDR_W-1:0] raddr;
		logic [ADDR_W-1:0] waddr;
		int rlen;
		m_arready = 1'b0;
		m_rvalid = 1'b0;
		m_rlast = 1'b0;
		m_rdata = '0;
		m_awready = 1'b0;
		m_wready = 1'b0;
		m_bvalid = 1'b0;
		forever begin
			@(negedge clk);
			if (m_arvalid) begin
				raddr = m_araddr;
				rlen = int'(m_arlen);
				repeat ($urandom_range(3, 0)) @(negedge clk);
				m_arready = 1'b1;
				@(negedge clk);
				m_arready = 1'b0;
				for (int i = 0; i <= rlen; i++) begin
					repeat ($urandom_range(3, 0)) @(negedge clk);
					m_rvalid = 1'b1;
					m_rdata = mem_word(raddr + 32'(i * 8));
					m_rlast = (i == rlen);
					@(negedge clk);
					m_rvalid = 1'b0;
					m_rlast = 1'b0;
				end
			end else if (m_awvalid) begin
				waddr = m_awaddr;
				repeat ($urandom_range(3, 0)) @(negedge clk);
				m_awready = 1'b1;
				@(negedge clk);
				m_awready = 1'b0;
				repeat ($urandom_range(3, 0)) @(negedge clk);
				// the data beat is taken only once the master offers it
				while (!m_wvalid)
					@(negedge clk);
				m_wready = 1'b1;
				mem[waddr[ADDR_W-1:3]] = mem_word(waddr);
				for (int b = 0; b < STRB_W; b++)
					if (m_wstrb[b])
						mem[waddr[ADDR_W-1:3]][b*8 +: 8] = m_wdata[b*8 +: 8];
				@(negedge clk);
				m_wready = 1'b0;
				repeat ($urandom_range(3, 0)) @(negedge clk);
				m_bvalid = 1'b1;
				@(negedge clk);
				m_bvalid = 1'b0;
			end
		end
	end

	// limit grows with every request handed to the dut
	initial begin
		while (cycles <= 200 * issued + 1000) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: dut stopped making progress after %0d requests", issued);
		$display("Checks failed");
		$finish;
	end

	// present one request on the falling edge while ready is high
	task automatic issue(input logic wren, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] wstrb);
		while (!req_ready) begin
			req_valid = 1'b0;
			@(negedge clk);
		end
		req_valid = 1'b1;
		req_wren = wren;
		req_addr = addr;
		req_wdata = wdata;
		req_wstrb = wstrb;
		issued++;
		@(negedge clk);
	endtask

	// wait for all responses
	task automatic drain();
		req_valid = 1'b0;
		@(negedge clk);
		while (u_mon.pending != 0)
			@(negedge clk);
	endtask

	task automatic snap();
		ar_l0 = u_mon.ar_line;
		ar_s0 = u_mon.ar_single;
		aw0 = u_mon.aw_cnt;
		slow0 = u_mon.slow_cnt;
		rsp0 = u_mon.rsp_cnt;
	endtask

	task automatic check_count(input string name, input int exp, input int got);
		if (exp != got) begin
			$display("CHECK FAILED %s expected %h got %h", name, exp, got);
			tb_err++;
		end
	endtask

	task automatic end_test(input string name);
		int now;
		now = tb_err + u_mon.err_cnt;
		$display("test %0d %s: %0d errors", test_no, name, now - err_base);
		err_base = now;
		test_no++;
	endtask

	initial begin
		logic [ADDR_W-1:0] a;
		logic [ADDR_W-1:0] unc;
		void'($urandom(32'h450a));
		rst = 1'b1;
		req_valid = 1'b0;
		req_wren = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		req_wstrb = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// cold miss fills one line with one burst
		snap();
		issue(1'b0, line_addr(4, 0, 2), '0, '0);
		drain();
		check_count("ar_line_bursts", 1, u_mon.ar_line - ar_l0);
		check_count("ar_single_beats", 0, u_mon.ar_single - ar_s0);
		end_test("cold read miss");

		// hits stream back to back without memory traffic
		snap();
		issue(1'b0, line_addr(4, 0, 2), '0, '0);
		issue(1'b0, line_addr(4, 0, 3), '0, '0);
		issue(1'b0, line_addr(4, 0, 7), '0, '0);
		drain();
		check_count("ar_line_bursts", 0, u_mon.ar_line - ar_l0);
		check_count("ar_single_beats", 0, u_mon.ar_single - ar_s0);
		check_count("hit_responses", 3, u_mon.rsp_cnt - rsp0);
		check_count("late_hit_responses", 0, u_mon.slow_cnt - slow0);
		end_test("repeated read hits");

		// partial write hit then readback of the merged word
		snap();
		issue(1'b1, line_addr(4, 0, 5), 64'h1122_3344_5566_7788, 8'h0f);
		drain();
		check_count("aw_count", 1, u_mon.aw_cnt - aw0);
		check_count("m_wstrb", 32'h0f, int'(u_mon.last_wstrb));
		issue(1'b0, line_addr(4, 0, 5), '0, '0);
		drain();
		check_count("ar_line_bursts", 0, u_mon.ar_line - ar_l0);
		end_test("write hit partial strobes");

		// write miss goes around the cache and the read refills the line
		snap();
		issue(1'b1, line_addr(9, 3, 1), 64'hdead_beef_cafe_f00d, 8'hf0);
		drain();
		check_count("ar_line_bursts", 0, u_mon.ar_line - ar_l0);
		check_count("ar_single_beats", 0, u_mon.ar_single - ar_s0);
		issue(1'b0, line_addr(9, 3, 1), '0, '0);
		drain();
		check_count("ar_line_bursts", 1, u_mon.ar_line - ar_l0);
		end_test("write miss then read");

		// uncached space never fills so every access reaches memory
		snap();
		unc = 32'h9000_0040;
		issue(1'b0, unc, '0, '0);
		issue(1'b0, unc, '0, '0);
		issue(1'b1, unc, 64'h0123_4567_89ab_cdef, 8'h3c);
		issue(1'b0, unc, '0, '0);
		drain();
		check_count("ar_single_beats", 3, u_mon.ar_single - ar_s0);
		check_count("ar_line_bursts", 0, u_mon.ar_line - ar_l0);
		check_count("aw_count", 1, u_mon.aw_cnt - aw0);
		end_test("uncached access");

		// 6 sets x 4 tags fit the ways but the victim pointer still evicts
		for (int i = 0; i < 400; i++) begin
			a = line_addr(16 + $urandom_range(3, 0), $urandom_range(5, 0),
				$urandom_range(7, 0));
			issue($urandom_range(3, 0) == 0, a, {$urandom, $urandom},
				8'($urandom_range(255, 1)));
		end
		drain();
		end_test("random mix");

		$display("summary: %0d requests, %0d responses, %0d errors",
			issued, u_mon.rsp_cnt, tb_err + u_mon.err_cnt);
		if (tb_err == 0 && u_mon.err_cnt == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
